// ==== hci.f ====
design/hci_pkg.sv
design/hci_queue.sv
design/hci_csr.sv
design/hci_cmd_issuer.sv
design/hci_top.sv
testbench/hci_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= hci_tb
FILELIST  ?= hci.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/hci_tb.sv ====
/* Table-driven testbench for the PIO queue front end, with command scoreboard,
   response and credit models, LFSR data and a cycle timeout */
`timescale 1ns/1ps
`default_nettype none

module hci_tb;

  localparam int unsigned CmdDepth  = 8;
  localparam int unsigned RespDepth = 8;

  typedef enum logic [2:0] {OpWrite, OpRead, OpPush, OpCredit, OpIdle} op_e;

  typedef struct packed {
    op_e                 op;
    hci_pkg::hci_addr_t  addr;
    hci_pkg::hci_dword_t data;
    hci_pkg::hci_dword_t exp;      // Read data
    logic                exp_err;
    logic [15:0]         emits;    // Commands out before this step
  } step_t;

  logic                  clk_i;
  logic                  rst_ni;
  hci_pkg::hci_csr_req_t csr_req_i;
  hci_pkg::hci_csr_rsp_t csr_rsp_o;
  hci_pkg::hci_cmd_t     cmd_o;
  logic                  cmd_valid_o;
  logic                  cmd_credit_i;
  logic                  resp_valid_i;
  hci_pkg::hci_resp_t    resp_i;
  logic                  resp_credit_o;
  logic                  cmd_ready_thld_trig_o;
  logic                  resp_ready_thld_trig_o;

  // Reference model of the DUT state, used while the table is built
  hci_pkg::hci_cmd_t   mdl_cmd_q[$];
  hci_pkg::hci_resp_t  mdl_resp_q[$];
  hci_pkg::hci_dword_t mdl_lo;
  logic                mdl_half;
  int unsigned         mdl_credits;
  int unsigned         mdl_emitted;
  hci_pkg::hci_level_t mdl_cmd_thld;
  hci_pkg::hci_level_t mdl_resp_thld;

  hci_pkg::hci_cmd_t exp_cmds[$];  // Scoreboard in emission order
  step_t             steps[$];
  logic [31:0]       lfsr_q;
  int unsigned       resp_credits;  // Controller side response credits
  int unsigned       cmds_seen     = 0;
  int unsigned       errors        = 0;
  int unsigned       checks        = 0;
  int unsigned       cycle_cnt     = 0;
  int unsigned       timeout_limit = 0;
  int unsigned       step_idx      = 0;

  hci_top #(
    .CmdDepth (CmdDepth),
    .RespDepth(RespDepth)
  ) hci_top_i (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .csr_rsp_o,
    .cmd_o,
    .cmd_valid_o,
    .cmd_credit_i,
    .resp_valid_i,
    .resp_i,
    .resp_credit_o,
    .cmd_ready_thld_trig_o,
    .resp_ready_thld_trig_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic hci_pkg::hci_dword_t next_rand_word();
    hci_pkg::hci_dword_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w      = {w[30:0], lfsr_q[0]};
    end
    return w;
  endfunction

  function automatic hci_pkg::hci_level_t clamped(input logic [7:0] v, input int unsigned depth);
    if (v == 8'd0) begin
      return 8'd1;
    end
    if (32'(v) > depth) begin
      return 8'(depth);
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED step %0d: %s got 0x%0h expected 0x%0h", step_idx, name, got, exp);
    end
  endtask

  // Adds one step with its expected results, then updates the model
  task automatic plan_step(input op_e op, input hci_pkg::hci_addr_t addr,
                           input hci_pkg::hci_dword_t data);
    step_t               s;
    hci_pkg::hci_cmd_t   cmd;
    hci_pkg::hci_level_t cmd_lvl;
    hci_pkg::hci_level_t resp_lvl;
    logic                cmd_trig;
    logic                resp_trig;
    s = '{op: op, addr: addr, data: data, exp: '0, exp_err: 1'b0, emits: 16'(mdl_emitted)};
    cmd_lvl   = 8'(mdl_cmd_q.size());
    resp_lvl  = 8'(mdl_resp_q.size());
    cmd_trig  = (8'(CmdDepth) - cmd_lvl) >= mdl_cmd_thld;  // Free slots
    resp_trig = resp_lvl >= mdl_resp_thld;
    if (op == OpWrite) begin
      case (addr)
        hci_pkg::AddrCmdPort: begin
          s.exp_err = (mdl_cmd_q.size() == CmdDepth);
          if (!s.exp_err && mdl_half) begin
            cmd.hi   = data;
            cmd.lo   = mdl_lo;
            mdl_half = 1'b0;
            mdl_cmd_q.push_back(cmd);
          end else if (!s.exp_err) begin
            mdl_lo   = data;
            mdl_half = 1'b1;
          end
        end
        hci_pkg::AddrQueueThld: begin
          mdl_cmd_thld  = clamped(data[7:0], CmdDepth);
          mdl_resp_thld = clamped(data[15:8], RespDepth);
        end
        hci_pkg::AddrResetCtrl: begin
          if (data[0]) begin
            mdl_cmd_q.delete();
            mdl_half = 1'b0;
          end
        end
        default: s.exp_err = 1'b1;
      endcase
    end else if (op == OpRead) begin
      case (addr)
        hci_pkg::AddrRespPort: begin
          if (mdl_resp_q.size() == 0) begin
            s.exp_err = 1'b1;
          end else begin
            s.exp = mdl_resp_q.pop_front();
          end
        end
        hci_pkg::AddrQueueThld:   s.exp = {16'h0, mdl_resp_thld, mdl_cmd_thld};
        hci_pkg::AddrResetCtrl:   s.exp = '0;
        hci_pkg::AddrQueueStatus: s.exp = {14'h0, resp_trig, cmd_trig, resp_lvl, cmd_lvl};
        default:                  s.exp_err = 1'b1;
      endcase
    end else if (op == OpPush) begin
      mdl_resp_q.push_back(data);
    end else if (op == OpCredit) begin
      mdl_credits++;
    end
    steps.push_back(s);
    // At most one command leaves per step
    while (mdl_credits != 0 && mdl_cmd_q.size() != 0) begin
      exp_cmds.push_back(mdl_cmd_q.pop_front());
      mdl_credits--;
      mdl_emitted++;
    end
  endtask

  task automatic plan_command();
    plan_step(OpWrite, hci_pkg::AddrCmdPort, next_rand_word());
    plan_step(OpWrite, hci_pkg::AddrCmdPort, next_rand_word());
  endtask

  task automatic build_table();
    plan_step(OpRead, hci_pkg::AddrQueueThld, '0);
    plan_step(OpRead, hci_pkg::AddrQueueStatus, '0);
    repeat (3) plan_command();  // Held back without credits
    plan_step(OpIdle, '0, '0);
    plan_step(OpRead, hci_pkg::AddrQueueStatus, '0);
    repeat (2) plan_step(OpCredit, '0, '0);
    plan_step(OpIdle, '0, '0);
    plan_step(OpRead, hci_pkg::AddrQueueStatus, '0);
    plan_step(OpCredit, '0, '0);
    plan_step(OpIdle, '0, '0);
    // One command more than fits
    repeat (CmdDepth + 1) plan_command();
    plan_step(OpRead, hci_pkg::AddrQueueStatus, '0);
    repeat (CmdDepth) plan_step(OpCredit, '0, '0);
    plan_step(OpIdle, '0, '0);
    plan_step(OpRead, hci_pkg::AddrQueueStatus, '0);
    plan_step(OpWrite, hci_pkg::AddrQueueThld, 32'h0000_ffff);
    plan_step(OpRead, hci_pkg::AddrQueueThld, '0);
    plan_step(OpWrite, hci_pkg::AddrQueueThld, 32'h0000_0000);
    plan_step(OpRead, hci_pkg::AddrQueueThld, '0);
    plan_step(OpWrite, hci_pkg::AddrQueueThld, 32'h0000_0304);
    plan_step(OpRead, hci_pkg::AddrQueueThld, '0);
    repeat (5) begin
      plan_command();
      plan_step(OpRead, hci_pkg::AddrQueueStatus, '0);
    end
    repeat (RespDepth) begin
      plan_step(OpPush, '0, next_rand_word());
      plan_step(OpRead, hci_pkg::AddrQueueStatus, '0);
    end
    repeat (RespDepth) begin
      plan_step(OpRead, hci_pkg::AddrRespPort, '0);
      plan_step(OpRead, hci_pkg::AddrQueueStatus, '0);
    end
    plan_step(OpRead, hci_pkg::AddrRespPort, '0);  // Empty
    repeat (2) plan_step(OpPush, '0, next_rand_word());  // Needs returned credits
    repeat (2) plan_step(OpRead, hci_pkg::AddrRespPort, '0);
    // Half a command, then the queue reset
    plan_step(OpWrite, hci_pkg::AddrCmdPort, next_rand_word());
    plan_step(OpWrite, hci_pkg::AddrResetCtrl, 32'h1);
    plan_step(OpRead, hci_pkg::AddrResetCtrl, '0);
    plan_step(OpRead, hci_pkg::AddrQueueStatus, '0);
    repeat (2) plan_command();
    repeat (3) plan_step(OpCredit, '0, '0);
    repeat (2) plan_step(OpIdle, '0, '0);
    plan_step(OpRead, hci_pkg::AddrQueueStatus, '0);
  endtask

  // Request cycle, then acknowledge cycle
  task automatic apply_step(input step_t s);
    logic exp_pulse;
    exp_pulse = (s.op == OpRead) && (s.addr == hci_pkg::AddrRespPort) && !s.exp_err;
    @(posedge clk_i);
    #1;
    case (s.op)
      OpWrite, OpRead: begin
        csr_req_i = '{req: 1'b1, is_wr: s.op == OpWrite, addr: s.addr, wdata: s.data};
      end
      OpPush: begin
        assert (resp_credits != 0) else begin
          errors++;
          $display("Step %0d pushes a response without a controller credit", step_idx);
        end
        if (resp_credits != 0) begin
          resp_credits--;
        end
        resp_valid_i = 1'b1;
        resp_i       = s.data;
      end
      OpCredit: cmd_credit_i = 1'b1;
      default: ;
    endcase
    @(negedge clk_i);
    check_value("resp_credit_o", 64'(resp_credit_o), 64'(exp_pulse));
    if (resp_credit_o) begin
      resp_credits++;
    end
    if (s.op == OpRead && s.addr == hci_pkg::AddrQueueStatus) begin
      check_value("cmd_ready_thld_trig_o", 64'(cmd_ready_thld_trig_o), 64'(s.exp[16]));
      check_value("resp_ready_thld_trig_o", 64'(resp_ready_thld_trig_o), 64'(s.exp[17]));
    end
    @(posedge clk_i);
    #1;
    csr_req_i    = '0;
    resp_valid_i = 1'b0;
    cmd_credit_i = 1'b0;
    check_value("commands emitted", 64'(cmds_seen), 64'(s.emits));
    @(negedge clk_i);
    check_value("csr_rsp_o.rd_ack", 64'(csr_rsp_o.rd_ack), 64'(s.op == OpRead));
    check_value("csr_rsp_o.wr_ack", 64'(csr_rsp_o.wr_ack), 64'(s.op == OpWrite));
    check_value("csr_rsp_o.err", 64'(csr_rsp_o.err), 64'(s.exp_err));
    if (s.op == OpRead) begin
      check_value("csr_rsp_o.rdata", 64'(csr_rsp_o.rdata), 64'(s.exp));
    end
  endtask

  // Controller side command monitor
  always @(negedge clk_i) begin
    if (rst_ni && cmd_valid_o) begin
      assert (cmds_seen < exp_cmds.size()) else begin
        errors++;
        $display("A command was emitted at step %0d while none was expected", step_idx);
      end
      if (cmds_seen < exp_cmds.size()) begin
        check_value("cmd_o", 64'(cmd_o), 64'(exp_cmds[cmds_seen]));
      end
      cmds_seen++;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
      $display("Simulation timed out after %0d cycles", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    rst_ni        = 1'b0;
    csr_req_i     = '0;
    cmd_credit_i  = 1'b0;
    resp_valid_i  = 1'b0;
    resp_i        = '0;
    lfsr_q        = 32'hfd18_b62f;
    mdl_lo        = '0;
    mdl_half      = 1'b0;
    mdl_credits   = 0;
    mdl_emitted   = 0;
    mdl_cmd_thld  = hci_pkg::ThldResetValue;
    mdl_resp_thld = hci_pkg::ThldResetValue;
    resp_credits  = RespDepth;
    build_table();
    timeout_limit = (steps.size() + 8) * 8;  // Reset and drain margin
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("cmd_valid_o", 64'(cmd_valid_o), 64'h0);
    check_value("resp_credit_o", 64'(resp_credit_o), 64'h0);
    check_value("csr_rsp_o", 64'(csr_rsp_o), 64'h0);
    check_value("cmd_ready_thld_trig_o", 64'(cmd_ready_thld_trig_o), 64'h1);
    check_value("resp_ready_thld_trig_o", 64'(resp_ready_thld_trig_o), 64'h0);
    for (int i = 0; i < steps.size(); i++) begin
      step_idx = i;
      apply_step(steps[i]);
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_value("total commands emitted", 64'(cmds_seen), 64'(exp_cmds.size()));
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/hci_top.sv ====
/* PIO queue front end top level with CSR block, command and response queues
   and the command issuer */
`timescale 1ns/1ps
`default_nettype none

module hci_top #(
  parameter int unsigned CmdDepth  = 8,
  parameter int unsigned RespDepth = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  hci_pkg::hci_csr_req_t csr_req_i,
  output hci_pkg::hci_csr_rsp_t csr_rsp_o,
  output hci_pkg::hci_cmd_t     cmd_o,
  output logic                  cmd_valid_o,
  input  logic                  cmd_credit_i,
  input  logic                  resp_valid_i,
  input  hci_pkg::hci_resp_t    resp_i,
  output logic                  resp_credit_o,
  output logic                  cmd_ready_thld_trig_o,
  output logic                  resp_ready_thld_trig_o
);

  logic                cmd_push;
  hci_pkg::hci_cmd_t   cmd_push_data;
  logic                cmd_full;
  logic                cmd_empty;
  hci_pkg::hci_level_t cmd_level;
  logic                cmd_flush;
  logic                cmd_pop;
  hci_pkg::hci_cmd_t   cmd_head;
  logic                resp_pop;
  hci_pkg::hci_resp_t  resp_head;
  logic                resp_empty;
  hci_pkg::hci_level_t resp_level;

  assign resp_credit_o = resp_pop;  // One credit back per pop

  hci_csr #(
    .CmdDepth (CmdDepth),
    .RespDepth(RespDepth)
  ) hci_csr_i (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .csr_rsp_o,
    .cmd_push_o            (cmd_push),
    .cmd_push_data_o       (cmd_push_data),
    .cmd_full_i            (cmd_full),
    .cmd_level_i           (cmd_level),
    .cmd_flush_o           (cmd_flush),
    .resp_pop_o            (resp_pop),
    .resp_head_i           (resp_head),
    .resp_empty_i          (resp_empty),
    .resp_level_i          (resp_level),
    .cmd_ready_thld_trig_o,
    .resp_ready_thld_trig_o
  );

  hci_queue #(
    .payload_t(hci_pkg::hci_cmd_t),
    .Depth    (CmdDepth)
  ) cmd_queue (
    .clk_i,
    .rst_ni,
    .flush_i    (cmd_flush),
    .push_i     (cmd_push),
    .push_data_i(cmd_push_data),
    .pop_i      (cmd_pop),
    .head_o     (cmd_head),
    .full_o     (cmd_full),
    .empty_o    (cmd_empty),
    .level_o    (cmd_level)
  );

  // Never flushed since the controller owns the response credits
  hci_queue #(
    .payload_t(hci_pkg::hci_resp_t),
    .Depth    (RespDepth)
  ) resp_queue (
    .clk_i,
    .rst_ni,
    .flush_i    (1'b0),
    .push_i     (resp_valid_i),
    .push_data_i(resp_i),
    .pop_i      (resp_pop),
    .head_o     (resp_head),
    .full_o     (),
    .empty_o    (resp_empty),
    .level_o    (resp_level)
  );

  hci_cmd_issuer hci_cmd_issuer_i (
    .clk_i,
    .rst_ni,
    .cmd_credit_i,
    .queue_empty_i(cmd_empty),
    .queue_head_i (cmd_head),
    .queue_pop_o  (cmd_pop),
    .cmd_o,
    .cmd_valid_o
  );

endmodule

`default_nettype wire

// ==== design/hci_cmd_issuer.sv ====
/* Credit counter that pops the command queue and drives commands to the controller */
`timescale 1ns/1ps
`default_nettype none

module hci_cmd_issuer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              cmd_credit_i,
  input  logic              queue_empty_i,
  input  hci_pkg::hci_cmd_t queue_head_i,
  output logic              queue_pop_o,
  output hci_pkg::hci_cmd_t cmd_o,
  output logic              cmd_valid_o
);

  hci_pkg::hci_credit_t credit_q;

  // Send only while the controller has a slot for it
  assign queue_pop_o = (credit_q != '0) && !queue_empty_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q    <= '0;
      cmd_valid_o <= 1'b0;
    end else begin
      cmd_valid_o <= queue_pop_o;
      case ({cmd_credit_i, queue_pop_o})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;  // Credit in and out cancel
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (queue_pop_o) begin
      cmd_o <= queue_head_i;
    end
  end

  credit_overflow_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) cmd_credit_i && !queue_pop_o |-> credit_q != '1
  ) else $error("hci_cmd_issuer: credit counter overflow");

endmodule

`default_nettype wire

// ==== design/hci_csr.sv ====
/* CSR decode, command DWORD assembly, response port reads,
   queue thresholds with clamping and the command queue reset bit */
`timescale 1ns/1ps
`default_nettype none

module hci_csr #(
  parameter int unsigned CmdDepth  = 8,
  parameter int unsigned RespDepth = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  hci_pkg::hci_csr_req_t csr_req_i,
  output hci_pkg::hci_csr_rsp_t csr_rsp_o,
  output logic                  cmd_push_o,
  output hci_pkg::hci_cmd_t     cmd_push_data_o,
  input  logic                  cmd_full_i,
  input  hci_pkg::hci_level_t   cmd_level_i,
  output logic                  cmd_flush_o,
  output logic                  resp_pop_o,
  input  hci_pkg::hci_resp_t    resp_head_i,
  input  logic                  resp_empty_i,
  input  hci_pkg::hci_level_t   resp_level_i,
  output logic                  cmd_ready_thld_trig_o,
  output logic                  resp_ready_thld_trig_o
);

  localparam hci_pkg::hci_level_t CmdMax  = hci_pkg::hci_level_t'(CmdDepth);
  localparam hci_pkg::hci_level_t RespMax = hci_pkg::hci_level_t'(RespDepth);

  hci_pkg::hci_csr_rsp_t rsp_d;
  hci_pkg::hci_csr_rsp_t rsp_q;
  hci_pkg::hci_dword_t   lo_q;
  logic                  half_q;  // First DWORD held
  hci_pkg::hci_level_t   cmd_thld_q;
  hci_pkg::hci_level_t   resp_thld_q;
  logic                  cmd_rst_q;
  logic                  cmd_rst_d;
  logic                  wr;
  logic                  rd;
  logic                  cmd_wr_ok;
  logic                  thld_we;
  hci_pkg::hci_level_t   cmd_free;

  function automatic hci_pkg::hci_level_t clamp_thld(input hci_pkg::hci_level_t val,
                                                     input hci_pkg::hci_level_t max_val);
    if (val == '0) begin
      return hci_pkg::hci_level_t'(1);
    end
    if (val > max_val) begin
      return max_val;
    end
    return val;
  endfunction

  assign wr = csr_req_i.req && csr_req_i.is_wr;
  assign rd = csr_req_i.req && !csr_req_i.is_wr;

  assign cmd_free               = CmdMax - cmd_level_i;
  assign cmd_ready_thld_trig_o  = (cmd_free >= cmd_thld_q);
  assign resp_ready_thld_trig_o = (resp_level_i >= resp_thld_q);

  assign cmd_push_data_o = '{hi: csr_req_i.wdata, lo: lo_q};
  assign cmd_push_o      = cmd_wr_ok && half_q;
  assign cmd_flush_o     = cmd_rst_q;
  assign csr_rsp_o       = rsp_q;

  always_comb begin
    rsp_d        = '0;
    rsp_d.rd_ack = rd;
    rsp_d.wr_ack = wr;
    cmd_wr_ok    = 1'b0;
    thld_we      = 1'b0;
    cmd_rst_d    = 1'b0;
    resp_pop_o   = 1'b0;
    if (wr) begin
      case (csr_req_i.addr)
        hci_pkg::AddrCmdPort: begin
          rsp_d.err = cmd_full_i;  // DWORD dropped when full
          cmd_wr_ok = !cmd_full_i;
        end
        hci_pkg::AddrQueueThld: thld_we = 1'b1;
        hci_pkg::AddrResetCtrl: cmd_rst_d = csr_req_i.wdata[0];
        default: rsp_d.err = 1'b1;
      endcase
    end
    if (rd) begin
      case (csr_req_i.addr)
        hci_pkg::AddrRespPort: begin
          if (resp_empty_i) begin
            rsp_d.err = 1'b1;
          end else begin
            resp_pop_o  = 1'b1;  // Also returns a credit
            rsp_d.rdata = resp_head_i;
          end
        end
        hci_pkg::AddrQueueThld: rsp_d.rdata = {16'h0, resp_thld_q, cmd_thld_q};
        hci_pkg::AddrResetCtrl: rsp_d.rdata = '0;  // Self-clearing bit reads 0
        hci_pkg::AddrQueueStatus: begin
          rsp_d.rdata = {14'h0, resp_ready_thld_trig_o, cmd_ready_thld_trig_o,
                         resp_level_i, cmd_level_i};
        end
        default: rsp_d.err = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q       <= '0;
      half_q      <= 1'b0;
      cmd_rst_q   <= 1'b0;
      cmd_thld_q  <= hci_pkg::ThldResetValue;
      resp_thld_q <= hci_pkg::ThldResetValue;
    end else begin
      rsp_q     <= rsp_d;
      cmd_rst_q <= cmd_rst_d;  // Self-clearing
      if (cmd_rst_q) begin
        half_q <= 1'b0;  // Flush drops a half command
      end else if (cmd_wr_ok) begin
        half_q <= !half_q;
      end
      if (thld_we) begin
        cmd_thld_q  <= clamp_thld(csr_req_i.wdata[7:0], CmdMax);
        resp_thld_q <= clamp_thld(csr_req_i.wdata[15:8], RespMax);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_wr_ok && !half_q) begin
      lo_q <= csr_req_i.wdata;
    end
  end

  ack_exclusive_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(csr_rsp_o.rd_ack && csr_rsp_o.wr_ack)
  ) else $error("hci_csr: rd_ack and wr_ack together");

endmodule

`default_nettype wire

// ==== design/hci_queue.sv ====
/* Generic synchronous FIFO with fill level, flush and type-parameter payload */
`timescale 1ns/1ps
`default_nettype none

module hci_queue #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 8
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                push_i,
  input  payload_t            push_data_i,
  input  logic                pop_i,
  output payload_t            head_o,
  output logic                full_o,
  output logic                empty_o,
  output hci_pkg::hci_level_t level_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam logic [PtrW-1:0] LastPtr = PtrW'(Depth - 1);

  payload_t            mem_q [Depth];
  logic [PtrW-1:0]     wr_ptr_q;
  logic [PtrW-1:0]     rd_ptr_q;
  hci_pkg::hci_level_t count_q;
  logic                push_en;
  logic                pop_en;

  // A full queue still takes a push when the head leaves in the same cycle
  assign push_en = push_i && (!full_o || pop_i);
  assign pop_en  = pop_i && !empty_o;

  assign full_o  = (count_q == hci_pkg::hci_level_t'(Depth));
  assign empty_o = (count_q == '0);
  assign level_o = count_q;
  assign head_o  = mem_q[rd_ptr_q];  // Head visible without pop

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en && !flush_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  initial begin
    assert (Depth >= 2 && Depth <= 255)
      else $fatal(1, "hci_queue: Depth %0d outside 2..255", Depth);
  end

  // Credit flow upstream must keep the queue from overflowing
  push_when_full_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_i && full_o && !flush_i |-> pop_i
  ) else $error("hci_queue: push into full queue");

  pop_when_empty_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o
  ) else $error("hci_queue: pop from empty queue");

endmodule

`default_nettype wire

// ==== design/hci_pkg.sv ====
/* CSR map, payload, CSR bus and counter types for the HCI PIO queue front end */
`default_nettype none

package hci_pkg;

  typedef logic [31:0] hci_dword_t;
  typedef logic [31:0] hci_resp_t;   // Response descriptor
  typedef logic [5:0]  hci_addr_t;   // CSR byte address
  typedef logic [7:0]  hci_level_t;  // Fill level or threshold
  typedef logic [7:0]  hci_credit_t;

  // Command as assembled from two port writes
  typedef struct packed {
    hci_dword_t hi;  // Second DWORD
    hci_dword_t lo;  // First DWORD
  } hci_cmd_t;

  typedef struct packed {
    logic       req;
    logic       is_wr;
    hci_addr_t  addr;
    hci_dword_t wdata;
  } hci_csr_req_t;

  typedef struct packed {
    logic       rd_ack;
    logic       wr_ack;
    logic       err;
    hci_dword_t rdata;
  } hci_csr_rsp_t;

  localparam hci_addr_t AddrCmdPort     = 6'h00;  // WO
  localparam hci_addr_t AddrRespPort    = 6'h04;  // RO, pops
  localparam hci_addr_t AddrQueueThld   = 6'h08;  // [7:0] cmd empty buf, [15:8] resp buf
  localparam hci_addr_t AddrResetCtrl   = 6'h0C;  // [0] CMD_QUEUE_RST
  localparam hci_addr_t AddrQueueStatus = 6'h10;  // RO levels and triggers

  localparam hci_level_t ThldResetValue = 8'd1;

endpackage

`default_nettype wire
